//--- hdl/hyper_lsab_pkg.sv
`default_nettype none

package hyper_lsab_pkg;

	// Load/store assist buffer geometry.
	localparam int LSAB_SECTIONS = 4; // Sections in the buffer.
	localparam int LSAB_WORD_W = 16; // Buffer word width.
	localparam int SECTION_W = 2; // Width of a section number.

	// DRAM side of the mover.
	localparam int DRAM_ADDR_W = 12; // Word address, bit 0 picks the half column.
	localparam int DRAM_DATA_W = 32; // One column holds two buffer words.
	localparam int DRAM_LANES = DRAM_DATA_W / 8; // Byte lanes per column.

	// Requested and sent word counts.
	localparam int COUNT_W = 6;

	// Block mover states.
	typedef enum logic [1:0]
	{
		MV_IDLE = 2'd0, // Waiting for a command.
		MV_MOVE = 2'd1, // Popping words and writing columns.
		MV_FLUSH = 2'd2, // Writing out a dangling even word.
		MV_DONE = 2'd3 // Publishing the word count.
	} mover_state_e;

endpackage

`default_nettype wire

//--- hdl/hyper_lsab_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module hyper_lsab_ingress #(
	parameter int SECTION_DEPTH = 32
) (
	input wire logic CLK,
	input wire logic RST,
	input wire logic wr_valid,
	input wire logic [hyper_lsab_pkg::SECTION_W-1:0] wr_section,
	input wire logic [hyper_lsab_pkg::LSAB_WORD_W-1:0] wr_data,
	input wire logic [hyper_lsab_pkg::LSAB_SECTIONS-1:0] pop_seen,
	output logic [hyper_lsab_pkg::LSAB_SECTIONS-1:0] push,
	output logic [hyper_lsab_pkg::LSAB_WORD_W-1:0] push_data,
	output logic overflow
);
	import hyper_lsab_pkg::*;

	localparam int OCC_W = $clog2(SECTION_DEPTH + 1);

	logic wr_valid_q;
	logic [SECTION_W-1:0] wr_section_q;
	logic [LSAB_WORD_W-1:0] wr_data_q;
	logic [OCC_W-1:0] occ [LSAB_SECTIONS]; // Mirror of each section's fill.
	logic sel_full;

	// Producer write stage.
	always_ff @(posedge CLK)
	begin
		if (!RST)
			wr_valid_q <= 1'b0;
		else
			wr_valid_q <= wr_valid;
		wr_section_q <= wr_section;
		wr_data_q <= wr_data;
	end

	assign sel_full = (occ[wr_section_q] == OCC_W'(SECTION_DEPTH));
	assign push_data = wr_data_q;

	// One-hot steer, dropped when the mirror is full.
	always_comb
	begin
		for (int s = 0; s < LSAB_SECTIONS; s++)
			push[s] = wr_valid_q && (wr_section_q == SECTION_W'(s)) && !sel_full;
	end

	// The pop credit arrives a cycle late, so the mirror never under-counts.
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			overflow <= 1'b0;
			for (int s = 0; s < LSAB_SECTIONS; s++)
				occ[s] <= '0;
		end
		else
		begin
			if (wr_valid_q && sel_full)
				overflow <= 1'b1; // Sticky.
			for (int s = 0; s < LSAB_SECTIONS; s++)
			begin
				case ({push[s], pop_seen[s]})
					2'b10: occ[s] <= occ[s] + 1'b1;
					2'b01: occ[s] <= occ[s] - 1'b1;
					default: occ[s] <= occ[s];
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/hyper_lsab_section.sv
`timescale 1ns/1ps
`default_nettype none

module hyper_lsab_section #(
	parameter int SECTION_DEPTH = 32
) (
	input wire logic CLK,
	input wire logic RST,
	input wire logic push,
	input wire logic [hyper_lsab_pkg::LSAB_WORD_W-1:0] push_data,
	input wire logic pop,
	output logic [hyper_lsab_pkg::LSAB_WORD_W-1:0] head,
	output logic empty,
	output logic credit_return
);
	import hyper_lsab_pkg::*;

	localparam int PTR_W = $clog2(SECTION_DEPTH);
	localparam int CNT_W = $clog2(SECTION_DEPTH + 1);

	logic [LSAB_WORD_W-1:0] mem [SECTION_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign head = mem[rd_ptr]; // Fall-through head word.
	assign do_pop = pop && !empty;
	assign do_push = push && (count != CNT_W'(SECTION_DEPTH));

	always_ff @(posedge CLK)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	// Pointers wrap naturally, depth is a power of two.
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
			credit_return <= do_pop; // One credit per word taken.
		end
	end

endmodule

`default_nettype wire

//--- hdl/hyper_mvblck_todram.sv
`timescale 1ns/1ps
`default_nettype none

module hyper_mvblck_todram (
	input wire logic CLK,
	input wire logic RST,
	input wire logic [hyper_lsab_pkg::LSAB_SECTIONS-1:0] lsab_empty,
	input wire logic [hyper_lsab_pkg::LSAB_SECTIONS*hyper_lsab_pkg::LSAB_WORD_W-1:0] lsab_head,
	input wire logic [hyper_lsab_pkg::DRAM_ADDR_W-1:0] start_address,
	input wire logic [hyper_lsab_pkg::COUNT_W-1:0] count_req,
	input wire logic [hyper_lsab_pkg::SECTION_W-1:0] section,
	input wire logic issue,
	output logic [hyper_lsab_pkg::LSAB_SECTIONS-1:0] lsab_pop,
	output logic [hyper_lsab_pkg::COUNT_W-1:0] count_sent,
	output logic working,
	output logic [hyper_lsab_pkg::DRAM_ADDR_W-1:0] mcu_coll_address,
	output logic [hyper_lsab_pkg::DRAM_LANES-1:0] mcu_we_array,
	output logic [hyper_lsab_pkg::DRAM_DATA_W-1:0] mcu_wdata,
	output logic mcu_request_access
);
	import hyper_lsab_pkg::*;

	mover_state_e state;
	logic [SECTION_W-1:0] sect_q;
	logic [DRAM_ADDR_W-1:0] addr_q; // Address of the next word.
	logic [COUNT_W-1:0] left_q;
	logic [COUNT_W-1:0] popped;
	logic [LSAB_WORD_W-1:0] even_data; // Low half of an open column.
	logic even_valid;
	logic sel_empty;
	logic [LSAB_WORD_W-1:0] sel_head;
	logic pop_now;

	assign sel_empty = lsab_empty[sect_q];
	assign sel_head = lsab_head[sect_q*LSAB_WORD_W +: LSAB_WORD_W];
	assign pop_now = (state == MV_MOVE) && !sel_empty && (left_q != '0);

	always_comb
	begin
		lsab_pop = '0;
		lsab_pop[sect_q] = pop_now;
	end

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state <= MV_IDLE;
			working <= 1'b0;
			mcu_request_access <= 1'b0;
			mcu_we_array <= '0;
			even_valid <= 1'b0;
			left_q <= '0;
			popped <= '0;
			count_sent <= '0;
			sect_q <= '0;
		end
		else
		begin
			working <= (state != MV_IDLE); // Lags the FSM by a cycle.
			mcu_request_access <= 1'b0;
			case (state)
				MV_IDLE:
				begin
					if (issue)
					begin
						sect_q <= section;
						addr_q <= start_address;
						left_q <= count_req;
						popped <= '0;
						even_valid <= 1'b0;
						state <= MV_MOVE;
					end
				end
				MV_MOVE:
				begin
					if (pop_now)
					begin
						addr_q <= addr_q + 1'b1;
						left_q <= left_q - 1'b1;
						popped <= popped + 1'b1;
						mcu_coll_address <= {addr_q[DRAM_ADDR_W-1:1], 1'b0};
						if (addr_q[0])
						begin
							// Odd word closes the column.
							mcu_request_access <= 1'b1;
							mcu_we_array <= {2'b11, {2{even_valid}}};
							mcu_wdata <= {sel_head, even_data};
							even_valid <= 1'b0;
						end
						else if (left_q == COUNT_W'(1))
						begin
							mcu_request_access <= 1'b1; // Last word lands low.
							mcu_we_array <= 4'b0011;
							mcu_wdata <= {{LSAB_WORD_W{1'b0}}, sel_head};
						end
						else
						begin
							even_data <= sel_head;
							even_valid <= 1'b1;
						end
					end
					else
						state <= even_valid ? MV_FLUSH : MV_DONE;
				end
				MV_FLUSH:
				begin
					// Section ran dry with half a column open.
					mcu_request_access <= 1'b1;
					mcu_coll_address <= {addr_q[DRAM_ADDR_W-1:1], 1'b0};
					mcu_we_array <= 4'b0011;
					mcu_wdata <= {{LSAB_WORD_W{1'b0}}, even_data};
					even_valid <= 1'b0;
					state <= MV_DONE;
				end
				MV_DONE:
				begin
					count_sent <= popped;
					state <= MV_IDLE;
				end
				default: state <= MV_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/hyper_todram_top.sv
`timescale 1ns/1ps
`default_nettype none

module hyper_todram_top #(
	parameter int SECTION_DEPTH = 32
) (
	input wire logic CLK,
	input wire logic RST,
	input wire logic wr_valid,
	input wire logic [hyper_lsab_pkg::SECTION_W-1:0] wr_section,
	input wire logic [hyper_lsab_pkg::LSAB_WORD_W-1:0] wr_data,
	output logic [hyper_lsab_pkg::LSAB_SECTIONS-1:0] credit_return,
	output logic overflow,
	input wire logic [hyper_lsab_pkg::DRAM_ADDR_W-1:0] start_address,
	input wire logic [hyper_lsab_pkg::COUNT_W-1:0] count_req,
	input wire logic [hyper_lsab_pkg::SECTION_W-1:0] section,
	input wire logic issue,
	output logic working,
	output logic [hyper_lsab_pkg::COUNT_W-1:0] count_sent,
	output logic [hyper_lsab_pkg::DRAM_ADDR_W-1:0] mcu_coll_address,
	output logic [hyper_lsab_pkg::DRAM_LANES-1:0] mcu_we_array,
	output logic [hyper_lsab_pkg::DRAM_DATA_W-1:0] mcu_wdata,
	output logic mcu_request_access
);
	import hyper_lsab_pkg::*;

	logic [LSAB_SECTIONS-1:0] push;
	logic [LSAB_WORD_W-1:0] push_data;
	logic [LSAB_SECTIONS-1:0] lsab_pop;
	logic [LSAB_SECTIONS-1:0] lsab_empty;
	logic [LSAB_SECTIONS*LSAB_WORD_W-1:0] lsab_head; // Section s at bits s*16.

	hyper_lsab_ingress #(.SECTION_DEPTH(SECTION_DEPTH)) ingress_i (
		.CLK(CLK),
		.RST(RST),
		.wr_valid(wr_valid),
		.wr_section(wr_section),
		.wr_data(wr_data),
		.pop_seen(credit_return), // Same pulses the producer sees.
		.push(push),
		.push_data(push_data),
		.overflow(overflow)
	);

	for (genvar g = 0; g < LSAB_SECTIONS; g++)
	begin : gen_section
		hyper_lsab_section #(.SECTION_DEPTH(SECTION_DEPTH)) section_i (
			.CLK(CLK),
			.RST(RST),
			.push(push[g]),
			.push_data(push_data),
			.pop(lsab_pop[g]),
			.head(lsab_head[g*LSAB_WORD_W +: LSAB_WORD_W]),
			.empty(lsab_empty[g]),
			.credit_return(credit_return[g])
		);
	end

	hyper_mvblck_todram mover_i (
		.CLK(CLK),
		.RST(RST),
		.lsab_empty(lsab_empty),
		.lsab_head(lsab_head),
		.start_address(start_address),
		.count_req(count_req),
		.section(section),
		.issue(issue),
		.lsab_pop(lsab_pop),
		.count_sent(count_sent),
		.working(working),
		.mcu_coll_address(mcu_coll_address),
		.mcu_we_array(mcu_we_array),
		.mcu_wdata(mcu_wdata),
		.mcu_request_access(mcu_request_access)
	);

endmodule

`default_nettype wire

//--- dv/hyper_todram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hyper_todram_tb;
	import hyper_lsab_pkg::*;

	localparam int SECTION_DEPTH = 32;
	localparam int NUM_MOVES = 6;
	localparam int FILL_WORDS = 91;
	localparam int WATCHDOG_CYCLES = NUM_MOVES * (64 + 8) + FILL_WORDS + 200;
	localparam int COLUMNS = 1 << (DRAM_ADDR_W - 1);
	localparam int RING = 64; // Model queue storage per section.

	logic CLK;
	logic RST;
	logic wr_valid;
	logic [SECTION_W-1:0] wr_section;
	logic [LSAB_WORD_W-1:0] wr_data;
	logic [LSAB_SECTIONS-1:0] credit_return;
	logic overflow;
	logic [DRAM_ADDR_W-1:0] start_address;
	logic [COUNT_W-1:0] count_req;
	logic [SECTION_W-1:0] section;
	logic issue;
	logic working;
	logic [COUNT_W-1:0] count_sent;
	logic [DRAM_ADDR_W-1:0] mcu_coll_address;
	logic [DRAM_LANES-1:0] mcu_we_array;
	logic [DRAM_DATA_W-1:0] mcu_wdata;
	logic mcu_request_access;

	logic [DRAM_DATA_W-1:0] shadow_mem [COLUMNS]; // DRAM contents as written by the DUT.
	logic [DRAM_DATA_W-1:0] exp_mem [COLUMNS];
	logic [LSAB_WORD_W-1:0] model_ring [LSAB_SECTIONS][RING];
	int ring_head [LSAB_SECTIONS];
	int ring_len [LSAB_SECTIONS];
	logic [DRAM_ADDR_W-1:0] exp_addr_q [$]; // Expected MCU requests, in order.
	logic [DRAM_LANES-1:0] exp_we_q [$];
	logic [DRAM_ADDR_W-1:0] mon_addr;
	logic [DRAM_LANES-1:0] mon_we;
	int credits [LSAB_SECTIONS];
	int pulses [LSAB_SECTIONS];
	int check_errors;
	int other_errors;
	logic [31:0] lfsr;

	hyper_todram_top #(.SECTION_DEPTH(SECTION_DEPTH)) dut_i (
		.CLK(CLK),
		.RST(RST),
		.wr_valid(wr_valid),
		.wr_section(wr_section),
		.wr_data(wr_data),
		.credit_return(credit_return),
		.overflow(overflow),
		.start_address(start_address),
		.count_req(count_req),
		.section(section),
		.issue(issue),
		.working(working),
		.count_sent(count_sent),
		.mcu_coll_address(mcu_coll_address),
		.mcu_we_array(mcu_we_array),
		.mcu_wdata(mcu_wdata),
		.mcu_request_access(mcu_request_access)
	);

	always #4 CLK = ~CLK;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]}; // One step per bit.
		end
		return v;
	endfunction

	// Word n lands at start + n and columns close on odd words or at the end.
	function automatic int ref_move(input int sec, input int start, input int cnt);
		int sent;
		logic [DRAM_ADDR_W-1:0] a;
		logic [LSAB_WORD_W-1:0] w;
		logic open_even;
		sent = (cnt < ring_len[sec]) ? cnt : ring_len[sec];
		open_even = 1'b0;
		for (int n = 0; n < sent; n++)
		begin
			a = DRAM_ADDR_W'(start + n);
			w = model_ring[sec][ring_head[sec]];
			ring_head[sec] = (ring_head[sec] + 1) % RING;
			ring_len[sec]--;
			if (a[0])
			begin
				exp_mem[a[DRAM_ADDR_W-1:1]][31:16] = w;
				exp_addr_q.push_back({a[DRAM_ADDR_W-1:1], 1'b0});
				exp_we_q.push_back(open_even ? 4'b1111 : 4'b1100);
				open_even = 1'b0;
			end
			else
			begin
				exp_mem[a[DRAM_ADDR_W-1:1]][15:0] = w;
				open_even = 1'b1;
			end
		end
		if (open_even)
		begin
			exp_addr_q.push_back({a[DRAM_ADDR_W-1:1], 1'b0}); // Even word alone.
			exp_we_q.push_back(4'b0011);
		end
		return sent;
	endfunction

	task automatic write_word(input int sec, input logic [LSAB_WORD_W-1:0] data,
		input bit need_credit);
		@(posedge CLK);
		wr_valid <= 1'b1;
		wr_section <= SECTION_W'(sec);
		wr_data <= data;
		if (credits[sec] > 0)
		begin
			credits[sec]--;
			model_ring[sec][(ring_head[sec] + ring_len[sec]) % RING] = data;
			ring_len[sec]++;
		end
		else if (need_credit)
		begin
			other_errors++;
			$display("Write to section %0d attempted with no credit left", sec);
		end
	endtask

	task automatic wait_working(input logic level);
		int n;
		n = 0;
		while (working !== level && n < 100)
		begin
			@(posedge CLK);
			n++;
		end
		if (working !== level)
		begin
			other_errors++;
			$display("working did not go to %0d within 100 cycles", level);
		end
	endtask

	task automatic run_move(input int sec, input int start, input int cnt);
		int sent;
		@(posedge CLK);
		wr_valid <= 1'b0;
		repeat (4) @(posedge CLK); // Idle gap after the last write.
		sent = ref_move(sec, start, cnt);
		for (int s = 0; s < LSAB_SECTIONS; s++)
			pulses[s] = 0;
		start_address <= DRAM_ADDR_W'(start);
		count_req <= COUNT_W'(cnt);
		section <= SECTION_W'(sec);
		issue <= 1'b1;
		@(posedge CLK);
		issue <= 1'b0;
		wait_working(1'b1);
		wait_working(1'b0);
		if (count_sent !== COUNT_W'(sent))
		begin
			check_errors++;
			$display("CHECK FAILED count_sent: got %h expected %h", count_sent, COUNT_W'(sent));
		end
		if (exp_addr_q.size() != 0)
		begin
			other_errors++;
			$display("Move on section %0d left %0d MCU requests unsent", sec, exp_addr_q.size());
			exp_addr_q.delete();
			exp_we_q.delete();
		end
		for (int c = 0; c < COLUMNS; c++)
		begin
			if (shadow_mem[c] !== exp_mem[c])
			begin
				check_errors++;
				$display("CHECK FAILED dram[%h]: got %h expected %h", c, shadow_mem[c], exp_mem[c]);
			end
		end
		for (int s = 0; s < LSAB_SECTIONS; s++)
		begin
			if (pulses[s] != ((s == sec) ? sent : 0))
			begin
				check_errors++;
				$display("CHECK FAILED credit_return[%0d] pulses: got %h expected %h",
					s, pulses[s], (s == sec) ? sent : 0);
			end
		end
	endtask

	// DRAM model and credit monitor.
	always @(posedge CLK)
	begin
		if (mcu_request_access)
		begin
			if (exp_addr_q.size() == 0)
			begin
				other_errors++;
				$display("MCU request to column %h that no move should make", mcu_coll_address);
			end
			else
			begin
				mon_addr = exp_addr_q.pop_front();
				mon_we = exp_we_q.pop_front();
				if (mcu_coll_address !== mon_addr || mcu_we_array !== mon_we)
				begin
					check_errors++;
					$display("CHECK FAILED mcu_coll_address/mcu_we_array: got %h/%h expected %h/%h",
						mcu_coll_address, mcu_we_array, mon_addr, mon_we);
				end
			end
			for (int b = 0; b < DRAM_LANES; b++)
				if (mcu_we_array[b])
					shadow_mem[mcu_coll_address[DRAM_ADDR_W-1:1]][b*8 +: 8] = mcu_wdata[b*8 +: 8];
		end
		for (int s = 0; s < LSAB_SECTIONS; s++)
		begin
			if (credit_return[s])
			begin
				credits[s]++;
				pulses[s]++;
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Run timed out after %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

	initial
	begin
		CLK = 1'b0;
		RST = 1'b0;
		wr_valid = 1'b0;
		wr_section = '0;
		wr_data = '0;
		start_address = '0;
		count_req = '0;
		section = '0;
		issue = 1'b0;
		lfsr = 32'd32;
		check_errors = 0;
		other_errors = 0;
		for (int c = 0; c < COLUMNS; c++)
		begin
			shadow_mem[c] = (32'(c) * 32'h0001_0001) ^ 32'h5A5A_C3C3; // Both halves carry c.
			exp_mem[c] = shadow_mem[c];
		end
		for (int s = 0; s < LSAB_SECTIONS; s++)
		begin
			credits[s] = SECTION_DEPTH;
			pulses[s] = 0;
			ring_head[s] = 0;
			ring_len[s] = 0;
		end
		repeat (8) @(posedge CLK);
		RST <= 1'b1;
		repeat (2) @(posedge CLK);
		if ({working, mcu_request_access, credit_return, overflow} !== '0)
		begin
			check_errors++;
			$display("CHECK FAILED working,mcu_request_access,credit_return,overflow: got %h expected %h",
				{working, mcu_request_access, credit_return, overflow}, 7'h0);
		end

		// Sections 0, 1 and 3 filled interleaved, then section 2.
		for (int i = 0; i < 20; i++)
		begin
			write_word(0, LSAB_WORD_W'(take_bits(16)), 1'b1);
			if (i < 16)
				write_word(1, LSAB_WORD_W'(take_bits(16)), 1'b1);
			if (i < 12)
				write_word(3, LSAB_WORD_W'(take_bits(16)), 1'b1);
		end
		for (int i = 0; i < 10; i++)
			write_word(2, LSAB_WORD_W'(take_bits(16)), 1'b1);

		run_move(0, int'(take_bits(12)) & ~1, 20); // Even start, even count.
		run_move(1, int'(take_bits(12)) | 1, 16); // Odd start, half columns at both ends.
		run_move(2, int'(take_bits(12)), 30); // More than the fill.
		run_move(2, int'(take_bits(12)), 8); // Section already empty.
		run_move(3, int'(take_bits(12)), 12);
		for (int s = 0; s < LSAB_SECTIONS; s++)
		begin
			if (credits[s] != SECTION_DEPTH)
			begin
				check_errors++;
				$display("CHECK FAILED credits[%0d]: got %h expected %h", s, credits[s], SECTION_DEPTH);
			end
		end

		// One write past the credits must be dropped.
		for (int i = 0; i < SECTION_DEPTH + 1; i++)
			write_word(0, LSAB_WORD_W'(take_bits(16)), 1'b0);
		@(posedge CLK);
		wr_valid <= 1'b0;
		repeat (4) @(posedge CLK);
		if (overflow !== 1'b1)
		begin
			check_errors++;
			$display("CHECK FAILED overflow: got %h expected %h", overflow, 1'b1);
		end
		run_move(0, int'(take_bits(12)), 40);

		$display("Errors: %0d value checks, %0d other failures", check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- hyper_todram_top.f
hdl/hyper_lsab_pkg.sv
hdl/hyper_lsab_ingress.sv
hdl/hyper_lsab_section.sv
hdl/hyper_mvblck_todram.sv
hdl/hyper_todram_top.sv
dv/hyper_todram_tb.sv

//--- Bender.yml
package:
  name: hyper_todram

sources:
  # Shared widths and the mover state type.
  - files:
      - hdl/hyper_lsab_pkg.sv
  # Buffer sections, ingress, block mover and top level.
  - files:
      - hdl/hyper_lsab_ingress.sv
      - hdl/hyper_lsab_section.sv
      - hdl/hyper_mvblck_todram.sv
      - hdl/hyper_todram_top.sv
  # Testbench with the DRAM model.
  - target: test
    files:
      - dv/hyper_todram_tb.sv
